/* src/usb_desc_pkg.sv */
// shared types, descriptor layout, identity constants and string constants
package usb_desc_pkg;

    typedef logic [7:0]  rom_addr_t;   // byte address in descriptor store
    typedef logic [7:0]  desc_len_t;   // descriptor length or byte offset
    typedef logic [15:0] usb_id_t;     // vendor / product id
    typedef logic [7:0]  desc_byte_t;  // one descriptor byte

    // standard request wValue high byte codes
    typedef enum logic [7:0] {
        DT_DEVICE      = 8'd1,
        DT_CONFIG      = 8'd2,
        DT_STRING      = 8'd3,
        DT_QUALIFIER   = 8'd6,
        DT_OTHER_SPEED = 8'd7
    } desc_type_e;

    typedef struct packed {
        logic       valid;   // request strobe
        desc_type_e dtype;   // descriptor type
        logic [7:0] index;   // descriptor index
        desc_len_t  offset;  // byte within descriptor
    } desc_req_t;

    typedef struct packed {
        logic      valid;
        logic      hit;      // known descriptor, offset in range
        logic      last;     // final byte of descriptor
        rom_addr_t addr;     // store address of the byte
    } desc_loc_t;

    typedef struct packed {
        logic       valid;
        logic       hit;
        logic       last;
        desc_byte_t data;    // 0 on miss
    } desc_rsp_t;

    // identity
    localparam usb_id_t DEFAULT_VID  = 16'h33AA;
    localparam usb_id_t DEFAULT_PID  = 16'h0120;
    localparam usb_id_t VERSION_BCD  = 16'h0100;  // bcdDevice
    localparam usb_id_t LANG_ID_US   = 16'h0409;  // english (us)
    localparam bit      SELF_POWERED = 1'b0;
    localparam desc_byte_t MAX_PACKET0 = 8'd64;   // ep0 packet size

    // strings, ascii, first character in the top byte
    localparam int VENDOR_STR_LEN  = 5;
    localparam int PRODUCT_STR_LEN = 10;
    localparam int SERIAL_STR_LEN  = 4;
    localparam int MAX_STR_LEN     = 10;  // widest of the three
    localparam logic [8*VENDOR_STR_LEN-1:0]  VENDOR_STR  = "XXXXX";
    localparam logic [8*PRODUCT_STR_LEN-1:0] PRODUCT_STR = "USB Module";
    localparam logic [8*SERIAL_STR_LEN-1:0]  SERIAL_STR  = "0001";

    // store layout
    localparam rom_addr_t DEV_ADDR  = 8'd0;
    localparam desc_len_t DEV_LEN   = 8'd18;
    localparam rom_addr_t QUAL_ADDR = 8'd20;  // 2 pad bytes before
    localparam desc_len_t QUAL_LEN  = 8'd10;
    localparam rom_addr_t CFG_ADDR  = 8'd32;  // 2 pad bytes before
    localparam desc_len_t CFG_LEN   = 8'd55;  // cfg + 2 ifc + 4 ep

    localparam rom_addr_t STRLANG_ADDR = CFG_ADDR + CFG_LEN;
    localparam desc_len_t STRLANG_LEN  = 8'd4;

    localparam rom_addr_t STRVENDOR_ADDR = STRLANG_ADDR + STRLANG_LEN;
    localparam desc_len_t STRVENDOR_LEN  = desc_len_t'(2 + 2 * VENDOR_STR_LEN);

    localparam rom_addr_t STRPRODUCT_ADDR = STRVENDOR_ADDR + STRVENDOR_LEN;
    localparam desc_len_t STRPRODUCT_LEN  = desc_len_t'(2 + 2 * PRODUCT_STR_LEN);

    localparam rom_addr_t STRSERIAL_ADDR = STRPRODUCT_ADDR + STRPRODUCT_LEN;
    localparam desc_len_t STRSERIAL_LEN  = desc_len_t'(2 + 2 * SERIAL_STR_LEN);

    localparam rom_addr_t ROM_SIZE = STRSERIAL_ADDR + STRSERIAL_LEN;  // 135

endpackage

/* src/desc_locate.sv */
// pipeline stage 1, type/index/offset to store address with hit and last flags
`timescale 1ns/10ps

module desc_locate
    import usb_desc_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  desc_req_t i_req,
    output desc_loc_t o_loc
);

    logic      known;     // type and index name a stored descriptor
    rom_addr_t base;
    desc_len_t len;
    logic      hit_c;
    logic      last_c;

    always_comb begin
        known = 1'b0;
        base  = '0;
        len   = '0;
        case (i_req.dtype)
            DT_DEVICE: begin
                if (i_req.index == 8'd0) begin
                    known = 1'b1;
                    base  = DEV_ADDR;
                    len   = DEV_LEN;
                end
            end
            DT_CONFIG: begin
                if (i_req.index == 8'd0) begin  // single configuration
                    known = 1'b1;
                    base  = CFG_ADDR;
                    len   = CFG_LEN;
                end
            end
            DT_QUALIFIER: begin
                if (i_req.index == 8'd0) begin
                    known = 1'b1;
                    base  = QUAL_ADDR;
                    len   = QUAL_LEN;
                end
            end
            DT_STRING: begin
                known = 1'b1;
                case (i_req.index)
                    8'd0: begin
                        base = STRLANG_ADDR;
                        len  = STRLANG_LEN;
                    end
                    8'd1: begin
                        base = STRVENDOR_ADDR;
                        len  = STRVENDOR_LEN;
                    end
                    8'd2: begin
                        base = STRPRODUCT_ADDR;
                        len  = STRPRODUCT_LEN;
                    end
                    8'd3: begin
                        base = STRSERIAL_ADDR;
                        len  = STRSERIAL_LEN;
                    end
                    default: known = 1'b0;  // no interface strings
                endcase
            end
            DT_OTHER_SPEED: known = 1'b0;   // hs only, no other-speed cfg
            default:        known = 1'b0;   // unknown type code
        endcase
    end

    assign hit_c  = i_req.valid && known && (i_req.offset < len);
    assign last_c = hit_c && (i_req.offset == desc_len_t'(len - 8'd1));

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            o_loc <= '0;
        end else begin
            o_loc.valid <= i_req.valid;
            o_loc.hit   <= hit_c;
            o_loc.last  <= last_c;
            o_loc.addr  <= hit_c ? rom_addr_t'(base + i_req.offset) : '0;  // miss -> 0
        end
    end

    // every accepted byte lands inside the store
    assert property (@(posedge CLK) disable iff (RESET)
        o_loc.hit |-> (o_loc.addr < ROM_SIZE))
        else $error("desc_locate: hit address outside store");

endmodule

/* src/desc_id_select.sv */
// registered choice between run-time and default vendor / product ids
`timescale 1ns/10ps

module desc_id_select
    import usb_desc_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  usb_id_t i_vid,
    input  usb_id_t i_pid,
    output usb_id_t o_vid,   // feeds idVendor
    output usb_id_t o_pid    // feeds idProduct
);

    logic vid_ok;  // input id neither all-0 nor all-1
    logic pid_ok;

    assign vid_ok = (i_vid != 16'h0000) && (i_vid != 16'hFFFF);
    assign pid_ok = (i_pid != 16'h0000) && (i_pid != 16'hFFFF);

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            o_vid <= DEFAULT_VID;
            o_pid <= DEFAULT_PID;
        end else begin
            o_vid <= vid_ok ? i_vid : DEFAULT_VID;
            o_pid <= pid_ok ? i_pid : DEFAULT_PID;
        end
    end

endmodule

/* src/desc_static_rom.sv */
// device, qualifier and hs configuration byte table with inserted ids
`timescale 1ns/10ps

module desc_static_rom
    import usb_desc_pkg::*;
(
    input  rom_addr_t  i_addr,
    input  usb_id_t    i_vid,
    input  usb_id_t    i_pid,
    output desc_byte_t o_data
);

    localparam desc_byte_t CFG_ATTR = SELF_POWERED ? 8'hC0 : 8'h80;

    // zero bytes and padding fall to the default
    always_comb begin
        o_data = 8'h00;
        case (i_addr)
            // device descriptor
            DEV_ADDR + 8'd0:  o_data = DEV_LEN;            // bLength
            DEV_ADDR + 8'd1:  o_data = 8'h01;              // device
            DEV_ADDR + 8'd3:  o_data = 8'h02;              // bcdUSB 2.00
            DEV_ADDR + 8'd7:  o_data = MAX_PACKET0;
            DEV_ADDR + 8'd8:  o_data = i_vid[7:0];         // idVendor
            DEV_ADDR + 8'd9:  o_data = i_vid[15:8];
            DEV_ADDR + 8'd10: o_data = i_pid[7:0];         // idProduct
            DEV_ADDR + 8'd11: o_data = i_pid[15:8];
            DEV_ADDR + 8'd12: o_data = VERSION_BCD[7:0];   // bcdDevice
            DEV_ADDR + 8'd13: o_data = VERSION_BCD[15:8];
            DEV_ADDR + 8'd14: o_data = 8'h01;              // iManufacturer
            DEV_ADDR + 8'd15: o_data = 8'h02;              // iProduct
            DEV_ADDR + 8'd16: o_data = 8'h03;              // iSerialNumber
            DEV_ADDR + 8'd17: o_data = 8'h01;              // one config
            // device qualifier
            QUAL_ADDR + 8'd0: o_data = QUAL_LEN;
            QUAL_ADDR + 8'd1: o_data = 8'h06;              // qualifier
            QUAL_ADDR + 8'd3: o_data = 8'h02;              // bcdUSB 2.00
            QUAL_ADDR + 8'd7: o_data = MAX_PACKET0;
            QUAL_ADDR + 8'd8: o_data = 8'h01;              // one config
            // configuration header
            CFG_ADDR + 8'd0:  o_data = 8'h09;
            CFG_ADDR + 8'd1:  o_data = 8'h02;              // configuration
            CFG_ADDR + 8'd2:  o_data = CFG_LEN;            // wTotalLength lo, hi = 0
            CFG_ADDR + 8'd4:  o_data = 8'h02;              // two interfaces
            CFG_ADDR + 8'd5:  o_data = 8'h01;              // bConfigurationValue
            CFG_ADDR + 8'd7:  o_data = CFG_ATTR;
            CFG_ADDR + 8'd8:  o_data = 8'hFA;              // 500 mA
            // interface 0, cdc acm
            CFG_ADDR + 8'd9:  o_data = 8'h09;
            CFG_ADDR + 8'd10: o_data = 8'h04;              // interface
            CFG_ADDR + 8'd13: o_data = 8'h02;              // two endpoints
            CFG_ADDR + 8'd14: o_data = 8'h02;              // class cdc
            CFG_ADDR + 8'd15: o_data = 8'h02;              // subclass acm
            // ep 2 in, bulk 512
            CFG_ADDR + 8'd18: o_data = 8'h07;
            CFG_ADDR + 8'd19: o_data = 8'h05;              // endpoint
            CFG_ADDR + 8'd20: o_data = 8'h82;
            CFG_ADDR + 8'd21: o_data = 8'h02;              // bulk
            CFG_ADDR + 8'd23: o_data = 8'h02;              // 0x0200
            // ep 2 out, bulk 512
            CFG_ADDR + 8'd25: o_data = 8'h07;
            CFG_ADDR + 8'd26: o_data = 8'h05;
            CFG_ADDR + 8'd27: o_data = 8'h02;
            CFG_ADDR + 8'd28: o_data = 8'h02;
            CFG_ADDR + 8'd30: o_data = 8'h02;
            // interface 1, msc bulk-only scsi
            CFG_ADDR + 8'd32: o_data = 8'h09;
            CFG_ADDR + 8'd33: o_data = 8'h04;
            CFG_ADDR + 8'd34: o_data = 8'h01;              // bInterfaceNumber
            CFG_ADDR + 8'd36: o_data = 8'h02;              // two endpoints
            CFG_ADDR + 8'd37: o_data = 8'h08;              // class msc
            CFG_ADDR + 8'd38: o_data = 8'h06;              // scsi transparent
            CFG_ADDR + 8'd39: o_data = 8'h50;              // bulk-only
            // ep 1 in, bulk 512
            CFG_ADDR + 8'd41: o_data = 8'h07;
            CFG_ADDR + 8'd42: o_data = 8'h05;
            CFG_ADDR + 8'd43: o_data = 8'h81;
            CFG_ADDR + 8'd44: o_data = 8'h02;
            CFG_ADDR + 8'd46: o_data = 8'h02;
            // ep 1 out, bulk 512
            CFG_ADDR + 8'd48: o_data = 8'h07;
            CFG_ADDR + 8'd49: o_data = 8'h05;
            CFG_ADDR + 8'd50: o_data = 8'h01;
            CFG_ADDR + 8'd51: o_data = 8'h02;
            CFG_ADDR + 8'd53: o_data = 8'h02;
            default:          o_data = 8'h00;
        endcase
    end

endmodule

/* src/desc_string_rom.sv */
// language descriptor and utf-16le vendor, product, serial string bytes
`timescale 1ns/10ps

module desc_string_rom
    import usb_desc_pkg::*;
(
    input  rom_addr_t  i_addr,
    output desc_byte_t o_data
);

    // byte at offset off of a string descriptor, str right aligned
    function automatic desc_byte_t str_byte(
        input desc_len_t                    off,
        input logic [8*MAX_STR_LEN-1:0]     str,
        input int                           len
    );
        int ci;
        ci = int'(off >> 1) - 1;                     // character index
        if (off == 8'd0) begin
            return desc_byte_t'(2 + 2 * len);       // bLength
        end else if (off == 8'd1) begin
            return 8'h03;                           // string type
        end else if (off[0]) begin
            return 8'h00;                           // utf-16 high byte
        end else begin
            return str[(len - 1 - ci) * 8 +: 8];    // ascii char
        end
    endfunction

    always_comb begin
        o_data = 8'h00;
        if (i_addr >= STRLANG_ADDR && i_addr < STRVENDOR_ADDR) begin
            case (2'(i_addr - STRLANG_ADDR))
                2'd0: o_data = STRLANG_LEN;
                2'd1: o_data = 8'h03;
                2'd2: o_data = LANG_ID_US[7:0];     // 0x0409 lo first
                2'd3: o_data = LANG_ID_US[15:8];
                default: o_data = 8'h00;
            endcase
        end else if (i_addr >= STRVENDOR_ADDR && i_addr < STRPRODUCT_ADDR) begin
            o_data = str_byte(desc_len_t'(i_addr - STRVENDOR_ADDR), VENDOR_STR,
                              VENDOR_STR_LEN);
        end else if (i_addr >= STRPRODUCT_ADDR && i_addr < STRSERIAL_ADDR) begin
            o_data = str_byte(desc_len_t'(i_addr - STRPRODUCT_ADDR), PRODUCT_STR,
                              PRODUCT_STR_LEN);
        end else if (i_addr >= STRSERIAL_ADDR && i_addr < ROM_SIZE) begin
            o_data = str_byte(desc_len_t'(i_addr - STRSERIAL_ADDR), SERIAL_STR,
                              SERIAL_STR_LEN);
        end
    end

endmodule

/* src/desc_fetch.sv */
// pipeline stage 2, content source select and registered response
`timescale 1ns/10ps

module desc_fetch
    import usb_desc_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  desc_loc_t  i_loc,
    input  desc_byte_t i_static_data,  // device / qualifier / config
    input  desc_byte_t i_string_data,  // string descriptors
    output desc_rsp_t  o_rsp
);

    desc_byte_t data_c;

    // strings sit above the static block in the store
    always_comb begin
        if (!i_loc.hit) begin
            data_c = 8'h00;                 // miss reads 0
        end else if (i_loc.addr >= STRLANG_ADDR) begin
            data_c = i_string_data;
        end else begin
            data_c = i_static_data;
        end
    end

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            o_rsp <= '0;
        end else begin
            o_rsp.valid <= i_loc.valid;
            o_rsp.hit   <= i_loc.hit;
            o_rsp.last  <= i_loc.last;
            o_rsp.data  <= data_c;
        end
    end

    // hit is built upstream in desc_locate, never without a request
    assert property (@(posedge CLK) disable iff (RESET)
        o_rsp.hit |-> o_rsp.valid)
        else $error("desc_fetch: response hit without valid");

endmodule

/* src/usb_desc_top.sv */
// descriptor store top level, two-stage lookup pipeline plus content sources
`timescale 1ns/10ps

module usb_desc_top
    import usb_desc_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  desc_req_t i_req,   // one request per cycle max
    input  usb_id_t   i_vid,   // run-time vid, 0000/ffff = default
    input  usb_id_t   i_pid,   // run-time pid, 0000/ffff = default
    output desc_rsp_t o_rsp    // two cycles after request
);

    desc_loc_t  loc;            // stage 1 -> stage 2
    usb_id_t    vid_sel;
    usb_id_t    pid_sel;
    desc_byte_t static_data;
    desc_byte_t string_data;

    desc_locate u_locate (
        .CLK   (CLK),
        .RESET (RESET),
        .i_req (i_req),
        .o_loc (loc)
    );

    desc_id_select u_id_select (
        .CLK   (CLK),
        .RESET (RESET),
        .i_vid (i_vid),
        .i_pid (i_pid),
        .o_vid (vid_sel),
        .o_pid (pid_sel)
    );

    desc_static_rom u_static_rom (
        .i_addr (loc.addr),
        .i_vid  (vid_sel),
        .i_pid  (pid_sel),
        .o_data (static_data)
    );

    desc_string_rom u_string_rom (
        .i_addr (loc.addr),
        .o_data (string_data)
    );

    desc_fetch u_fetch (
        .CLK           (CLK),
        .RESET         (RESET),
        .i_loc         (loc),
        .i_static_data (static_data),
        .i_string_data (string_data),
        .o_rsp         (o_rsp)
    );

endmodule

/* bench/tb_usb_desc_table.svh */
// stimulus runs and expected descriptor bytes for the descriptor store testbench
// columns: dtype, index, offset, count, vid, pid / expected bytes, hit, last offset
localparam int NUM_ROWS = 16;
localparam row_t ROWS [NUM_ROWS] = '{
    // full device descriptor, zero ids select the defaults
    '{DT_DEVICE, 8'd0, 8'd0, 8'd18, 16'h0000, 16'h0000,
      176'h1201_0002_0000_0040_AA33_2001_0001_0102_0301, 1'b1, 8'd17},
    // run-time ids, low byte first
    '{DT_DEVICE, 8'd0, 8'd8, 8'd4, 16'h1234, 16'hABCD,
      176'h3412_CDAB, 1'b1, 8'hFF},
    // all ones falls back to the defaults
    '{DT_DEVICE, 8'd0, 8'd8, 8'd4, 16'hFFFF, 16'hFFFF,
      176'hAA33_2001, 1'b1, 8'hFF},
    '{DT_CONFIG, 8'd0, 8'd2, 8'd2, 16'hFFFF, 16'hFFFF,
      176'h3700, 1'b1, 8'hFF},      // wTotalLength 55
    '{DT_CONFIG, 8'd0, 8'd14, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h02, 1'b1, 8'hFF},        // cdc class
    '{DT_CONFIG, 8'd0, 8'd36, 8'd4, 16'hFFFF, 16'hFFFF,
      176'h0208_0650, 1'b1, 8'hFF}, // msc endpoints, class, subclass, protocol
    '{DT_CONFIG, 8'd0, 8'd54, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h00, 1'b1, 8'd54},        // last bInterval
    '{DT_QUALIFIER, 8'd0, 8'd1, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h06, 1'b1, 8'hFF},
    '{DT_STRING, 8'd0, 8'd0, 8'd4, 16'hFFFF, 16'hFFFF,
      176'h0403_0904, 1'b1, 8'd3},  // language id 0409
    // "XXXXX"
    '{DT_STRING, 8'd1, 8'd0, 8'd12, 16'hFFFF, 16'hFFFF,
      176'h0C03_5800_5800_5800_5800_5800, 1'b1, 8'd11},
    // "USB Module"
    '{DT_STRING, 8'd2, 8'd0, 8'd22, 16'hFFFF, 16'hFFFF,
      176'h1603_5500_5300_4200_2000_4D00_6F00_6400_7500_6C00_6500, 1'b1, 8'd21},
    // "0001"
    '{DT_STRING, 8'd3, 8'd0, 8'd10, 16'hFFFF, 16'hFFFF,
      176'h0A03_3000_3000_3000_3100, 1'b1, 8'd9},
    // misses, offset at length, other speed, string 4, config 1
    '{DT_DEVICE, 8'd0, 8'd18, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h00, 1'b0, 8'hFF},
    '{DT_OTHER_SPEED, 8'd0, 8'd0, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h00, 1'b0, 8'hFF},
    '{DT_STRING, 8'd4, 8'd0, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h00, 1'b0, 8'hFF},
    '{DT_CONFIG, 8'd1, 8'd0, 8'd1, 16'hFFFF, 16'hFFFF,
      176'h00, 1'b0, 8'hFF}
};

/* bench/tb_usb_desc.sv */
// testbench for the descriptor store, table loop with pipelined response checks
`timescale 1ns/10ps

module tb_usb_desc
    import usb_desc_pkg::*;
();

    typedef struct packed {
        desc_type_e   dtype;
        logic [7:0]   index;
        desc_len_t    offset;    // first offset of the run
        logic [7:0]   count;     // consecutive bytes requested
        usb_id_t      vid;
        usb_id_t      pid;
        logic [175:0] bytes;     // expected bytes, first one leftmost
        logic         hit;
        desc_len_t    last_off;  // offset that carries last, ff = none
    } row_t;

    typedef struct packed {
        logic [7:0]  row;        // table row of the request
        logic        tail;       // final request of its row
        logic        hit;
        logic        last;
        desc_byte_t  data;
        logic [31:0] cyc;        // cycle the request was driven in
    } exp_t;

    `include "tb_usb_desc_table.svh"

    logic        CLK = 1'b0;
    logic        RESET;
    desc_req_t   req;
    usb_id_t     vid;
    usb_id_t     pid;
    desc_rsp_t   rsp;
    exp_t        expq [$];       // requests in flight, oldest first
    int          row_err [0:255];
    logic [31:0] cycle = '0;     // falling edges since start
    int          checks = 0;
    int          errors = 0;
    int          tests_failed = 0;

    always #10 CLK = ~CLK;       // 20 ns period

    usb_desc_top DUT (
        .CLK   (CLK),
        .RESET (RESET),
        .i_req (req),
        .i_vid (vid),
        .i_pid (pid),
        .o_rsp (rsp)
    );

    task automatic report_row(input int row);
        if (row_err[row] != 0) begin
            tests_failed++;
        end
        $display("test %0d %s index %0d: %s, %0d error(s)", row, ROWS[row].dtype.name(),
                 ROWS[row].index, (row_err[row] == 0) ? "ok" : "FAIL", row_err[row]);
    endtask

    // response is stable half a cycle after the rising edge
    task automatic check_response();
        exp_t e;
        if (rsp.valid && expq.size() == 0) begin
            $display("response at %0t arrived with no request pending", $time);
            errors++;
        end else if (rsp.valid) begin
            e = expq.pop_front();
            checks++;
            assert (rsp.hit == e.hit && rsp.last == e.last && rsp.data == e.data
                    && cycle == e.cyc + 32'd2)
            else begin
                $display("ERR %0t test %0d: hit %b last %b data %h after %0d cycles, want %b %b %h",
                         $time, e.row, rsp.hit, rsp.last, rsp.data, cycle - e.cyc,
                         e.hit, e.last, e.data);
                errors++;
                row_err[e.row]++;
            end
            if (e.tail) report_row(int'(e.row));
        end else if (expq.size() != 0 && cycle > expq[0].cyc + 32'd2) begin
            e = expq.pop_front();
            $display("response of test %0d missing at %0t", e.row, $time);
            errors++;
            row_err[e.row]++;
            if (e.tail) report_row(int'(e.row));
        end
    endtask

    // next falling edge, check the output, then default to idle
    task automatic step();
        @(negedge CLK);
        cycle = cycle + 32'd1;
        check_response();
        req.valid = 1'b0;
    endtask

    initial begin
        exp_t      e;
        desc_len_t off;
        int        idles;
        int        wait_cnt;
        req   = '0;
        vid   = 16'h0000;
        pid   = 16'h0000;
        RESET = 1'b1;
        void'($urandom(32'h0130_5d60));
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ROWS[r].vid != vid || ROWS[r].pid != pid) begin
                step();
                vid = ROWS[r].vid;        // in-flight reads already past the rom
                pid = ROWS[r].pid;
                repeat (3) step();
            end else if (r > 0) begin
                idles = int'($urandom_range(2, 0));  // 0 gives back-to-back rows
                repeat (idles) step();
            end
            for (int k = 0; k < int'(ROWS[r].count); k++) begin
                step();
                off   = ROWS[r].offset + 8'(k);
                req   = '{1'b1, ROWS[r].dtype, ROWS[r].index, off};
                e.row = 8'(r);
                e.tail = (k == int'(ROWS[r].count) - 1);
                e.hit  = ROWS[r].hit;
                e.last = ROWS[r].hit && (off == ROWS[r].last_off);
                e.data = ROWS[r].bytes[(int'(ROWS[r].count) - 1 - k) * 8 +: 8];
                e.cyc  = cycle;
                expq.push_back(e);
            end
        end
        wait_cnt = 0;
        while (expq.size() != 0 && wait_cnt < 20) begin
            step();
            wait_cnt++;
        end
        if (expq.size() != 0) begin
            $display("timeout, %0d responses never arrived", expq.size());
            errors++;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_ROWS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
src/usb_desc_pkg.sv
src/desc_locate.sv
src/desc_id_select.sv
src/desc_static_rom.sv
src/desc_string_rom.sv
src/desc_fetch.sv
src/usb_desc_top.sv
bench/tb_usb_desc.sv

/* Makefile */
TOP := tb_usb_desc

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
